/* hw/uart_mmio_pkg.sv */
`include "uart_mmio_macros.svh"

package uart_mmio_pkg;

    // one serial payload
    typedef logic [7:0] uart_byte_t;

    // bus side
    typedef logic [31:0] mmio_word_t;
    typedef logic [31:0] mmio_addr_t;

    // counts clocks inside one bit time
    typedef logic [$clog2(`UART_CLKS_PER_BIT)-1:0] baud_count_t;

    // position within a frame
    typedef logic [3:0] bit_index_t;

endpackage

/* hw/uart_mmio_regs.sv */
`timescale 1ns/1ps
`include "uart_mmio_macros.svh"

module uart_mmio_regs
    import uart_mmio_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       load_i,
    input  logic       store_i,
    input  mmio_addr_t addr_i,
    input  mmio_word_t wdata_i,
    input  logic       rx_valid_i,
    input  uart_byte_t rx_byte_i,
    input  logic       tx_ready_i,
    output mmio_word_t rdata_o,
    output logic       rx_consume_o,
    output logic       tx_start_o,
    output uart_byte_t tx_byte_o
);

    localparam mmio_addr_t ADDR_STATUS = `MMIO_ADDR_STATUS;
    localparam mmio_addr_t ADDR_RX     = `MMIO_ADDR_RX;
    localparam mmio_addr_t ADDR_TX     = `MMIO_ADDR_TX;

    logic       hit_status;
    logic       hit_rx;
    logic       hit_tx;
    mmio_word_t status_word;
    mmio_word_t read_word;

    assign hit_status = (addr_i == ADDR_STATUS);
    assign hit_rx     = (addr_i == ADDR_RX);
    assign hit_tx     = (addr_i == ADDR_TX);

    // bit 1 byte waiting, bit 0 transmitter free
    assign status_word = {30'b0, rx_valid_i, tx_ready_i};

    always_comb begin
        if (hit_status) begin
            read_word = status_word;
        end else if (hit_rx) begin
            read_word = {24'b0, rx_byte_i};    // zero-extended
        end else begin
            read_word = '0;                     // unmapped
        end
    end

    // consume in the same cycle so the next status read already sees it
    assign rx_consume_o = load_i & hit_rx;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_o    <= '0;
            tx_start_o <= 1'b0;
        end else begin
            if (load_i) rdata_o <= read_word;  // held until the next load
            tx_start_o <= store_i & hit_tx;
        end
    end

    always_ff @(posedge clk) begin
        if (store_i && hit_tx) tx_byte_o <= wdata_i[7:0];
    end

    a_one_strobe: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !(load_i && store_i)
    ) else $error("uart_mmio_regs: load and store in the same cycle");

endmodule

/* hw/uart_mmio_top.sv */
`timescale 1ns/1ps

module uart_mmio_top
    import uart_mmio_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       load_i,
    input  logic       store_i,
    input  mmio_addr_t addr_i,
    input  mmio_word_t wdata_i,
    input  logic       serial_rx_i,
    output mmio_word_t rdata_o,
    output logic       serial_tx_o
);

    logic       rx_consume;
    logic       rx_valid;
    uart_byte_t rx_byte;
    logic       tx_start;
    uart_byte_t tx_byte;
    logic       tx_ready;

    uart_receiver u_rx (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .serial_rx_i  (serial_rx_i),
        .rx_consume_i (rx_consume),
        .rx_valid_o   (rx_valid),
        .rx_byte_o    (rx_byte)
    );

    uart_transmitter u_tx (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .tx_start_i  (tx_start),
        .tx_byte_i   (tx_byte),
        .tx_ready_o  (tx_ready),
        .serial_tx_o (serial_tx_o)
    );

    uart_mmio_regs u_regs (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .load_i       (load_i),
        .store_i      (store_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .rx_valid_i   (rx_valid),
        .rx_byte_i    (rx_byte),
        .tx_ready_i   (tx_ready),
        .rdata_o      (rdata_o),
        .rx_consume_o (rx_consume),
        .tx_start_o   (tx_start),
        .tx_byte_o    (tx_byte)
    );

endmodule

/* hw/uart_receiver.sv */
`timescale 1ns/1ps
`include "uart_mmio_macros.svh"

module uart_receiver
    import uart_mmio_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       serial_rx_i,
    input  logic       rx_consume_i,
    output logic       rx_valid_o,
    output uart_byte_t rx_byte_o
);

    localparam baud_count_t LAST_CLK = baud_count_t'(CLKS_PER_BIT - 1);
    localparam baud_count_t HALF_CLK = baud_count_t'(CLKS_PER_BIT / 2 - 1);
    localparam bit_index_t  LAST_BIT = bit_index_t'(7);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t   state;
    logic        rx_meta;
    logic        rx_sync;
    logic        rx_last;
    logic        rx_fall;
    baud_count_t baud_cnt;
    bit_index_t  bit_idx;
    uart_byte_t  rx_shift;
    logic        frame_ok;

    // two-stage synchronizer plus one for edge detect
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= serial_rx_i;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    assign rx_fall  = rx_last & ~rx_sync;
    assign frame_ok = (state == RX_STOP) && (baud_cnt == LAST_CLK) && rx_sync;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (rx_fall) state <= RX_START;
                end
                RX_START: begin
                    if (baud_cnt == HALF_CLK) begin  // mid start bit
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync ? RX_IDLE : RX_DATA; // glitch goes back
                    end
                end
                RX_DATA: begin
                    if (baud_cnt == LAST_CLK) begin
                        baud_cnt <= '0;
                        if (bit_idx == LAST_BIT) state <= RX_STOP;
                        else bit_idx <= bit_idx + 1'b1;
                    end
                end
                default: begin                       // RX_STOP
                    if (baud_cnt == LAST_CLK) state <= RX_IDLE;
                end
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && baud_cnt == LAST_CLK) rx_shift <= {rx_sync, rx_shift[7:1]};
        if (frame_ok) rx_byte_o <= rx_shift;   // a new frame overwrites the old byte
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_valid_o <= 1'b0;
        end else if (frame_ok) begin
            rx_valid_o <= 1'b1;
        end else if (rx_consume_i) begin
            rx_valid_o <= 1'b0;
        end
    end

    a_valid_held: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $fell(rx_valid_o) |-> $past(rx_consume_i)
    ) else $error("uart_receiver: rx_valid dropped without a consume");

endmodule

/* hw/uart_transmitter.sv */
`timescale 1ns/1ps
`include "uart_mmio_macros.svh"

module uart_transmitter
    import uart_mmio_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       tx_start_i,
    input  uart_byte_t tx_byte_i,
    output logic       tx_ready_o,
    output logic       serial_tx_o
);

    localparam int          FRAME_BITS = `UART_FRAME_BITS;
    localparam baud_count_t LAST_CLK   = baud_count_t'(CLKS_PER_BIT - 1);
    localparam bit_index_t  LAST_BIT   = bit_index_t'(FRAME_BITS - 1);

    logic [FRAME_BITS-1:0] tx_shift;    // bit 0 is on the line
    baud_count_t           baud_cnt;
    bit_index_t            bit_idx;
    logic                  busy;
    logic                  bit_done;

    assign bit_done = (baud_cnt == LAST_CLK);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_shift <= '1;                 // idle line is high
            baud_cnt <= '0;
            bit_idx  <= '0;
            busy     <= 1'b0;
        end else if (!busy) begin
            if (tx_start_i) begin
                tx_shift <= {1'b1, tx_byte_i, 1'b0}; // stop, data, start
                baud_cnt <= '0;
                bit_idx  <= '0;
                busy     <= 1'b1;
            end
        end else if (bit_done) begin
            baud_cnt <= '0;
            tx_shift <= {1'b1, tx_shift[FRAME_BITS-1:1]}; // next bit, refill with idle
            if (bit_idx == LAST_BIT) begin
                bit_idx <= '0;
                busy    <= 1'b0;            // stop bit finished
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign serial_tx_o = tx_shift[0];
    assign tx_ready_o  = ~busy;

    // the shifter must have drained back to all ones by the time we go idle
    a_idle_line_high: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        tx_ready_o |-> serial_tx_o
    ) else $error("uart_transmitter: line low while idle");

endmodule

/* include/uart_mmio_macros.svh */
`ifndef UART_MMIO_MACROS_SVH
`define UART_MMIO_MACROS_SVH

// serial timing
`define UART_CLOCK_FREQ    50_000_000
`define UART_BAUD_RATE     115200
`define UART_CLKS_PER_BIT  (`UART_CLOCK_FREQ / `UART_BAUD_RATE)

// start bit, eight data bits, stop bit
`define UART_FRAME_BITS    10

// memory-mapped register addresses
`define MMIO_ADDR_STATUS   32'h8000_0000
`define MMIO_ADDR_RX       32'h8000_0004
`define MMIO_ADDR_TX       32'h8000_0008

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the UART MMIO testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f uart_mmio.f \
    --top-module uart_mmio_tb \
    -o Vuart_mmio_tb

sim_out=$(./obj_dir/Vuart_mmio_tb 2>&1 || true)
echo "$sim_out"

if grep -q "Done: no errors" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

/* tb/uart_mmio_tb.sv */
`timescale 1ns/1ps
`include "uart_mmio_macros.svh"

module uart_mmio_tb
    import uart_mmio_pkg::*;
();

    localparam int         CLKS         = `UART_CLKS_PER_BIT;
    localparam int         FRAME_CYCLES = `UART_FRAME_BITS * CLKS;
    localparam int         RUN_FRAMES   = 8;    // frames the tests put on the two lines
    localparam int         WATCHDOG_CYCLES = RUN_FRAMES * FRAME_CYCLES * 6; // about 2 ms
    localparam mmio_addr_t ADDR_STATUS  = `MMIO_ADDR_STATUS;
    localparam mmio_addr_t ADDR_RX      = `MMIO_ADDR_RX;
    localparam mmio_addr_t ADDR_TX      = `MMIO_ADDR_TX;
    localparam mmio_addr_t ADDR_UNMAPPED = 32'h8000_000C;

    logic       clk;
    logic       arst_n_i;
    logic       load_i;
    logic       store_i;
    mmio_addr_t addr_i;
    mmio_word_t wdata_i;
    logic       serial_rx_i;
    mmio_word_t rdata_o;
    logic       serial_tx_o;

    int          value_errors = 0;
    int          other_errors = 0;
    logic [31:0] rng_state    = 32'h744d;
    uart_byte_t  tx_q[$];   // bytes decoded from serial_tx_o

    uart_mmio_top uut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .load_i      (load_i),
        .store_i     (store_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .serial_rx_i (serial_rx_i),
        .rdata_o     (rdata_o),
        .serial_tx_o (serial_tx_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // read word only moves after a load
    a_rdata_held: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !$past(load_i) |-> $stable(rdata_o)
    ) else begin
        value_errors = value_errors + 1;
        $display("FAILED at %0t: rdata_o changed without a load", $time);
    end

    // a frame starts only two edges after a store to the tx register
    a_frame_from_store: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $fell(uut.tx_ready) |-> $past(store_i && addr_i == ADDR_TX, 2)
    ) else begin
        value_errors = value_errors + 1;
        $display("FAILED at %0t: frame started without a store to the tx register", $time);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_byte(output uart_byte_t b);
        rng_state = xorshift32(rng_state);
        b = rng_state[7:0];
    endtask

    task automatic check_word(input mmio_word_t got, input mmio_word_t exp, input string what);
        assert (got == exp) else begin
            value_errors = value_errors + 1;
            $display("FAILED at %0t: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic bus_read(input mmio_addr_t addr, output mmio_word_t word);
        @(posedge clk);
        #1 load_i = 1'b1;
        addr_i = addr;
        @(posedge clk);
        #1 load_i = 1'b0;
        word = rdata_o;
    endtask

    task automatic bus_write(input mmio_addr_t addr, input mmio_word_t data);
        @(posedge clk);
        #1 store_i = 1'b1;
        addr_i  = addr;
        wdata_i = data;
        @(posedge clk);
        #1 store_i = 1'b0;
    endtask

    task automatic drive_bit(input logic b);
        @(posedge clk);
        #1 serial_rx_i = b;
        repeat (CLKS - 1) @(posedge clk);
    endtask

    task automatic send_frame(input uart_byte_t b);
        drive_bit(1'b0);                    // start
        for (int i = 0; i < 8; i++) drive_bit(b[i]);
        drive_bit(1'b1);                    // stop
    endtask

    task automatic wait_tx_idle();
        mmio_word_t word;
        int         polls;
        polls = 0;
        do begin
            bus_read(ADDR_STATUS, word);
            polls++;
        end while (!word[0] && polls < FRAME_CYCLES);
        if (!word[0]) begin
            other_errors = other_errors + 1;
            $display("transmitter did not become ready again within two frame times");
        end
    endtask

    // serial monitor, samples at mid-bit on the falling clock edge
    initial begin
        uart_byte_t b;
        wait (arst_n_i);
        forever begin
            @(negedge clk);
            if (serial_tx_o == 1'b0) begin
                repeat (CLKS / 2) @(negedge clk);
                if (serial_tx_o != 1'b0) begin
                    other_errors = other_errors + 1;
                    $display("start bit on serial_tx_o did not last to mid-bit at %0t", $time);
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS) @(negedge clk);
                    b = {serial_tx_o, b[7:1]};      // lsb first
                end
                repeat (CLKS) @(negedge clk);
                if (serial_tx_o != 1'b1) begin
                    other_errors = other_errors + 1;
                    $display("stop bit on serial_tx_o was low at %0t", $time);
                end
                tx_q.push_back(b);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        uart_byte_t b1;
        uart_byte_t b2;
        mmio_word_t word;
        arst_n_i    = 1'b0;
        load_i      = 1'b0;
        store_i     = 1'b0;
        addr_i      = '0;
        wdata_i     = '0;
        serial_rx_i = 1'b1;
        repeat (5) @(posedge clk);
        #1 arst_n_i = 1'b1;

        // reset state
        @(negedge clk);
        check_word({31'b0, serial_tx_o}, 32'h1, "serial_tx_o after reset");
        bus_read(ADDR_STATUS, word);
        check_word(word, 32'h1, "status after reset");

        // transmit one byte
        draw_byte(b1);
        tx_q.delete();
        bus_write(ADDR_TX, {24'b0, b1});
        repeat (CLKS) @(posedge clk);
        bus_read(ADDR_STATUS, word);
        check_word(word & 32'h1, 32'h0, "status bit 0 during frame");
        wait_tx_idle();
        check_word(tx_q.size(), 32'd1, "frames after one store");
        if (tx_q.size() > 0) check_word({24'b0, tx_q[0]}, {24'b0, b1}, "transmitted byte");

        // second store while busy is dropped
        draw_byte(b1);
        draw_byte(b2);
        tx_q.delete();
        bus_write(ADDR_TX, {24'b0, b1});
        repeat (20) @(posedge clk);
        bus_write(ADDR_TX, {24'b0, b2});
        wait_tx_idle();
        repeat (2 * CLKS) @(posedge clk);
        check_word(tx_q.size(), 32'd1, "frames after store while busy");
        if (tx_q.size() > 0) check_word({24'b0, tx_q[0]}, {24'b0, b1}, "byte kept while busy");

        // receive one byte
        draw_byte(b1);
        send_frame(b1);
        repeat (CLKS) @(posedge clk);
        bus_read(ADDR_STATUS, word);
        check_word(word, 32'h3, "status after a received frame");
        bus_read(ADDR_RX, word);
        check_word(word, {24'b0, b1}, "received byte");
        bus_read(ADDR_STATUS, word);
        check_word(word, 32'h1, "status after reading the byte");

        // overrun keeps the newer byte
        draw_byte(b1);
        draw_byte(b2);
        if (b2 == b1) b2 = ~b1;
        send_frame(b1);
        send_frame(b2);
        repeat (CLKS) @(posedge clk);
        bus_read(ADDR_STATUS, word);
        check_word(word, 32'h3, "status after two frames");
        bus_read(ADDR_RX, word);
        check_word(word, {24'b0, b2}, "byte after overrun");

        // unmapped addresses, read word is nonzero before the first one
        bus_read(ADDR_STATUS, word);
        check_word(word, 32'h1, "status after reading the overrun byte");
        bus_read(ADDR_UNMAPPED, word);
        check_word(word, 32'h0, "load of unmapped address");
        bus_read(32'h0000_0004, word);
        check_word(word, 32'h0, "load of low unmapped address");
        tx_q.delete();
        bus_write(ADDR_UNMAPPED, 32'h0000_00A5);
        repeat (FRAME_CYCLES + CLKS) @(posedge clk);
        check_word(tx_q.size(), 32'd0, "frames after unmapped store");
        bus_read(ADDR_STATUS, word);
        check_word(word, 32'h1, "status after unmapped store");

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* uart_mmio.f */
+incdir+include
hw/uart_mmio_pkg.sv
hw/uart_receiver.sv
hw/uart_transmitter.sv
hw/uart_mmio_regs.sv
hw/uart_mmio_top.sv
tb/uart_mmio_tb.sv
